/* include/motor_config.svh */
`ifndef MOTOR_CONFIG_SVH
`define MOTOR_CONFIG_SVH

// System clock rate in hertz
`define MOTOR_CLK_FREQUENCY 60_000_000

// PWM carrier rate in hertz
`define MOTOR_PWM_FREQUENCY 100_000

// Clocks per PWM period
`define MOTOR_PERIOD_COUNT (`MOTOR_CLK_FREQUENCY / `MOTOR_PWM_FREQUENCY)

// Clocks per one percent of duty
`define MOTOR_DUTY_1_PERCENT (`MOTOR_PERIOD_COUNT / 100)

// Applied duty change per PWM period, in percent
`define MOTOR_SLEW_STEP 1

`endif

/* rtl/motor_pkg.sv */
`default_nettype none

package motor_pkg;

    // Duty in percent
    // 0 to 100 meaningful, above 100 means full on
    typedef logic [6:0] duty_t;

    // Clock count within one PWM period
    typedef logic [9:0] period_count_t;

    // Clocks within a one-percent slice, or slices completed
    typedef logic [7:0] percent_count_t;

    // Action taken by the slew limiter at a period tick
    typedef enum logic [1:0] {
        HOLD,
        RAMP_UP,
        RAMP_DOWN,
        REVERSE
    } slew_state_t;

endpackage

`default_nettype wire

/* rtl/pwm_period_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_config.svh"

module pwm_period_timer import motor_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic en,
    output logic period_tick
);

    // Last count value before wrap
    localparam period_count_t PERIOD_LAST = period_count_t'(`MOTOR_PERIOD_COUNT - 1);

    period_count_t count;

    // Free-running period counter
    // Held at zero while disabled so the first tick is a full period after enable
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            period_tick <= 1'b0;
        end else begin
            period_tick <= 1'b0;
            if (!en) begin
                count <= '0;
            end else if (count == PERIOD_LAST) begin
                count <= '0;
                period_tick <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Tick is a single-clock pulse
    a_tick_single: assert property (
        @(posedge clk) disable iff (reset)
        period_tick |=> !period_tick
    );

endmodule

`default_nettype wire

/* rtl/duty_slew_limiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_config.svh"

module duty_slew_limiter import motor_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  logic  period_tick,
    input  duty_t duty_cmd,
    input  logic  dir_cmd,
    output duty_t duty_applied,
    output logic  dir_applied
);

    localparam duty_t DUTY_MAX = duty_t'(100);
    localparam duty_t SLEW_STEP = duty_t'(`MOTOR_SLEW_STEP);
    localparam logic FORWARD = 1'b0;

    // Action taken at the coming tick
    slew_state_t action;
    duty_t target;
    duty_t floor_duty;
    duty_t up_duty;
    duty_t down_duty;
    logic dir_differs;

    // Decide this tick's action from command and applied values
    always_comb begin
        // Anything above 100 is treated as full on
        target = (duty_cmd > DUTY_MAX) ? DUTY_MAX : duty_cmd;
        dir_differs = (dir_cmd != dir_applied);
        // Reversal must first ramp all the way to zero
        floor_duty = dir_differs ? duty_t'(0) : target;

        if (dir_differs && duty_applied == '0) begin
            action = REVERSE;
        end else if (duty_applied > floor_duty) begin
            action = RAMP_DOWN;
        end else if (!dir_differs && duty_applied < target) begin
            action = RAMP_UP;
        end else begin
            action = HOLD;
        end

        // Step toward the goal without overshooting it
        up_duty = (target - duty_applied > SLEW_STEP) ? duty_applied + SLEW_STEP : target;
        down_duty = (duty_applied - floor_duty > SLEW_STEP) ? duty_applied - SLEW_STEP
                                                             : floor_duty;
    end

    // Outputs move only on the period tick, or on brake
    always_ff @(posedge clk) begin
        if (reset) begin
            duty_applied <= '0;
            dir_applied <= FORWARD;
        end else if (!en) begin
            // Brake clears the ramp
            duty_applied <= '0;
            dir_applied <= FORWARD;
        end else if (period_tick) begin
            case (action)
                RAMP_UP:   duty_applied <= up_duty;
                RAMP_DOWN: duty_applied <= down_duty;
                // Flip at zero duty, duty itself held this tick
                REVERSE:   dir_applied <= dir_cmd;
                default:   duty_applied <= duty_applied;
            endcase
        end
    end

    // Direction flips only at zero duty, except on brake
    a_safe_reverse: assert property (
        @(posedge clk) disable iff (reset)
        $changed(dir_applied) |-> !$past(en) || ($past(duty_applied) == '0)
    );

    // Duty moves at ticks only, by at most one step
    a_slew_limit: assert property (
        @(posedge clk) disable iff (reset)
        ($past(en) && $changed(duty_applied)) |->
            $past(period_tick) &&
            ((duty_applied > $past(duty_applied)) ?
                (duty_applied - $past(duty_applied)) <= SLEW_STEP :
                ($past(duty_applied) - duty_applied) <= SLEW_STEP)
    );

endmodule

`default_nettype wire

/* rtl/pwm_dir.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_config.svh"

module pwm_dir import motor_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  logic  float,
    input  logic  period_tick,
    input  duty_t duty_cycle,
    input  logic  dir_in,
    output logic  pwm,
    output logic  dir_out,
    output logic  float_n
);

    localparam duty_t DUTY_FULL = duty_t'(100);
    localparam percent_count_t SLICE_LAST = percent_count_t'(`MOTOR_DUTY_1_PERCENT - 1);
    localparam logic FORWARD = 1'b0;

    // Duty captured at the period start, used for the whole period
    duty_t duty_latched;
    percent_count_t duty_slices;

    // Clocks within the current one-percent slice
    percent_count_t slice_count;
    // One-percent slices already completed
    percent_count_t slices_done;

    logic full_on;
    logic last_slice;

    // Driver IC sleep pin is active low
    assign float_n = ~float;

    assign duty_slices = percent_count_t'(duty_latched);
    // 100 and above stays high until the next tick
    assign full_on = (duty_latched >= DUTY_FULL);
    // Final slice of the pulse is in progress
    assign last_slice = (slices_done == duty_slices - 1'b1);

    always_ff @(posedge clk) begin
        if (period_tick) begin
            duty_latched <= duty_cycle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pwm <= 1'b0;
            dir_out <= FORWARD;
            slice_count <= '0;
            slices_done <= '0;
        end else if (!en) begin
            // Brake with both bridge inputs low
            pwm <= 1'b0;
            dir_out <= FORWARD;
            slice_count <= '0;
            slices_done <= '0;
        end else begin
            dir_out <= dir_in;

            if (period_tick) begin
                // New period, pulse starts unless duty is zero
                slice_count <= '0;
                slices_done <= '0;
                pwm <= (duty_cycle != '0);
            end else if (pwm && !full_on) begin
                if (slice_count == SLICE_LAST) begin
                    slice_count <= '0;
                    slices_done <= slices_done + 1'b1;
                    // Drop on the last clock of the final slice
                    if (last_slice) begin
                        pwm <= 1'b0;
                    end
                end else begin
                    slice_count <= slice_count + 1'b1;
                end
            end
        end
    end

    // Output stays low for a clock after enable was low
    a_brake_low: assert property (
        @(posedge clk) disable iff (reset)
        !$past(en) |-> !pwm
    );

endmodule

`default_nettype wire

/* rtl/dual_motor_drive.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_motor_drive import motor_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    output logic  pwm_sync,

    input  logic  left_float,
    input  duty_t left_duty_cmd,
    input  logic  left_dir_cmd,

    input  logic  right_float,
    input  duty_t right_duty_cmd,
    input  logic  right_dir_cmd,

    output logic  left_pwm,
    output logic  left_dir,
    output logic  left_float_n,

    output logic  right_pwm,
    output logic  right_dir,
    output logic  right_float_n
);

    logic period_tick;

    // Ramped values feeding each generator
    duty_t left_duty_applied;
    duty_t right_duty_applied;
    logic left_dir_applied;
    logic right_dir_applied;

    // Period start also serves as the ADC trigger
    assign pwm_sync = period_tick;

    // One shared timer keeps both channels in phase
    pwm_period_timer pwm_period_timer_inst (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .period_tick (period_tick)
    );

    duty_slew_limiter left_limiter_inst (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .period_tick  (period_tick),
        .duty_cmd     (left_duty_cmd),
        .dir_cmd      (left_dir_cmd),
        .duty_applied (left_duty_applied),
        .dir_applied  (left_dir_applied)
    );

    duty_slew_limiter right_limiter_inst (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .period_tick  (period_tick),
        .duty_cmd     (right_duty_cmd),
        .dir_cmd      (right_dir_cmd),
        .duty_applied (right_duty_applied),
        .dir_applied  (right_dir_applied)
    );

    pwm_dir left_pwm_inst (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .float       (left_float),
        .period_tick (period_tick),
        .duty_cycle  (left_duty_applied),
        .dir_in      (left_dir_applied),
        .pwm         (left_pwm),
        .dir_out     (left_dir),
        .float_n     (left_float_n)
    );

    pwm_dir right_pwm_inst (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .float       (right_float),
        .period_tick (period_tick),
        .duty_cycle  (right_duty_applied),
        .dir_in      (right_dir_applied),
        .pwm         (right_pwm),
        .dir_out     (right_dir),
        .float_n     (right_float_n)
    );

endmodule

`default_nettype wire

/* verification/dual_motor_checks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_config.svh"

module dual_motor_checks import motor_pkg::*; #(
    parameter string CHANNEL = "left"
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  logic  pwm_sync,
    input  logic  float,
    input  duty_t duty_cmd,
    input  logic  dir_cmd,
    input  logic  pwm,
    input  logic  dir,
    input  logic  float_n
);

    localparam int PERIOD = `MOTOR_PERIOD_COUNT;
    localparam int SLICE = `MOTOR_DUTY_1_PERCENT;

    int error_count = 0;

    // Reference ramp, stepped at every period start
    duty_t model_duty;
    logic model_dir;
    // Duty in force for the period being measured
    duty_t width_duty;
    int high_count;
    int sample_count;
    // A whole period has been seen since enable
    logic period_valid;

    // High clocks per period for a given duty
    function automatic int expected_width(input duty_t duty);
        return (duty >= 100) ? PERIOD : int'(duty) * SLICE;
    endfunction

    // One percent toward the clamped command, or toward zero before a reversal
    function automatic duty_t ramp_step(input duty_t applied, input logic applied_dir,
                                        input duty_t cmd, input logic cmd_dir);
        int goal;
        goal = (cmd > 100) ? 100 : int'(cmd);
        if (cmd_dir != applied_dir) begin
            goal = 0;
        end
        if (int'(applied) > goal) begin
            return applied - 1'b1;
        end else if (int'(applied) < goal) begin
            return applied + 1'b1;
        end
        return applied;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || !en) begin
            model_duty <= '0;
            model_dir <= 1'b0;
            width_duty <= '0;
            high_count <= 0;
            sample_count <= 0;
            period_valid <= 1'b0;
        end else if (pwm_sync) begin
            // Generator latches the duty from before this step
            width_duty <= model_duty;
            model_duty <= ramp_step(model_duty, model_dir, duty_cmd, dir_cmd);
            // Flip only once the duty has reached zero
            if (dir_cmd != model_dir && model_duty == '0) begin
                model_dir <= dir_cmd;
            end
            high_count <= 0;
            sample_count <= 0;
            period_valid <= 1'b1;
        end else begin
            high_count <= high_count + int'(pwm);
            sample_count <= sample_count + 1;
        end
    end

    task automatic report_value(input string check, input int expected, input int actual);
        error_count++;
        $display("FAIL %s %s %s: expected %0d actual %0d",
                 dual_motor_drive_tb.test_name, CHANNEL, check, expected, actual);
    endtask

    task automatic report_event(input string what);
        error_count++;
        $display("Error in test %s, %s channel: %s", dual_motor_drive_tb.test_name, CHANNEL, what);
    endtask

    a_tick_spacing: assert property (
        @(posedge clk) disable iff (reset)
        (en && pwm_sync && period_valid) |-> (sample_count + 1 == PERIOD)
    ) else report_value("tick spacing", PERIOD, $sampled(sample_count) + 1);

    // Measured window covers the samples after one tick up to the next
    a_pulse_width: assert property (
        @(posedge clk) disable iff (reset)
        (en && pwm_sync && period_valid) |->
            (high_count + int'(pwm) == expected_width(width_duty))
    ) else report_value("pulse width", expected_width($sampled(width_duty)),
                        $sampled(high_count) + int'($sampled(pwm)));

    // dir_out trails the applied direction by one clock
    a_dir_value: assert property (
        @(posedge clk) disable iff (reset)
        $past(en) |-> (dir == $past(model_dir))
    ) else report_value("direction", int'($past(model_dir)), int'($sampled(dir)));

    a_safe_reversal: assert property (
        @(posedge clk) disable iff (reset)
        ($past(en) && $changed(dir)) |-> (width_duty == '0)
    ) else report_event("direction changed in a period with nonzero pulse width");

    a_brake: assert property (
        @(posedge clk) disable iff (reset)
        !$past(en) |-> (!pwm && !dir)
    ) else report_event("pwm high or direction reverse while braked");

    a_coast: assert property (
        @(posedge clk) disable iff (reset)
        float_n == !float
    ) else report_value("coast output", int'(!$sampled(float)), int'($sampled(float_n)));

endmodule

`default_nettype wire

/* verification/dual_motor_drive_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_config.svh"

module dual_motor_drive_tb import motor_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int PERIOD = `MOTOR_PERIOD_COUNT;
    localparam int RANDOM_SEGMENTS = 40;
    localparam int SEGMENT_MAX_PERIODS = 6;
    // Directed test lengths plus the worst case of the random segments
    localparam int TOTAL_PERIODS = 3 + 105 + 85 + 40 + 21
                                 + RANDOM_SEGMENTS * (SEGMENT_MAX_PERIODS + 1);
    localparam longint WATCHDOG_NS = longint'(TOTAL_PERIODS + 50) * PERIOD * CLK_PERIOD_NS;

    logic clk;
    logic reset;
    logic en;
    logic pwm_sync;
    logic left_float;
    logic right_float;
    duty_t left_duty_cmd;
    duty_t right_duty_cmd;
    logic left_dir_cmd;
    logic right_dir_cmd;
    logic left_pwm;
    logic left_dir;
    logic left_float_n;
    logic right_pwm;
    logic right_dir;
    logic right_float_n;

    string test_name = "reset";
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;
    logic [31:0] rng_state = 32'h7c0;

    dual_motor_drive dual_motor_drive_inst (
        .clk            (clk),
        .reset          (reset),
        .en             (en),
        .pwm_sync       (pwm_sync),
        .left_float     (left_float),
        .left_duty_cmd  (left_duty_cmd),
        .left_dir_cmd   (left_dir_cmd),
        .right_float    (right_float),
        .right_duty_cmd (right_duty_cmd),
        .right_dir_cmd  (right_dir_cmd),
        .left_pwm       (left_pwm),
        .left_dir       (left_dir),
        .left_float_n   (left_float_n),
        .right_pwm      (right_pwm),
        .right_dir      (right_dir),
        .right_float_n  (right_float_n)
    );

    dual_motor_checks #(.CHANNEL("left")) left_checks (
        .clk(clk), .reset(reset), .en(en), .pwm_sync(pwm_sync),
        .float(left_float), .duty_cmd(left_duty_cmd), .dir_cmd(left_dir_cmd),
        .pwm(left_pwm), .dir(left_dir), .float_n(left_float_n)
    );

    dual_motor_checks #(.CHANNEL("right")) right_checks (
        .clk(clk), .reset(reset), .en(en), .pwm_sync(pwm_sync),
        .float(right_float), .duty_cmd(right_duty_cmd), .dir_cmd(right_dir_cmd),
        .pwm(right_pwm), .dir(right_dir), .float_n(right_float_n)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_errors();
        return left_checks.error_count + right_checks.error_count;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = lcg_step(rng_state);
        value = rng_state;
    endtask

    // Returns on the falling edge inside each period start pulse
    task automatic wait_periods(input int count);
        repeat (count) begin
            @(negedge clk);
            while (!pwm_sync) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test();
        int new_errors;
        // Period checks fire on the edge after the sync pulse
        @(negedge clk);
        new_errors = total_errors() - errors_at_start;
        tests_run++;
        if (new_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s %s with %0d errors", test_name,
                 (new_errors == 0) ? "passed" : "failed", new_errors);
    endtask

    task automatic command(input duty_t left_duty, input logic left_dir_in,
                           input duty_t right_duty, input logic right_dir_in);
        left_duty_cmd = left_duty;
        left_dir_cmd = left_dir_in;
        right_duty_cmd = right_duty;
        right_dir_cmd = right_dir_in;
    endtask

    // Run limit from the summed test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired in test %s before the tests finished", test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        en = 1'b0;
        left_float = 1'b0;
        right_float = 1'b0;
        command(7'd0, 1'b0, 7'd0, 1'b0);
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        en = 1'b1;

        begin_test("tick_spacing");
        wait_periods(3);
        end_test();

        // Right is commanded past 100 and must saturate at a full period
        begin_test("ramp_up");
        command(7'd12, 1'b0, 7'd127, 1'b0);
        wait_periods(105);
        end_test();

        begin_test("ramp_down");
        command(7'd3, 1'b0, 7'd20, 1'b0);
        wait_periods(85);
        end_test();

        begin_test("safe_reversal");
        command(7'd8, 1'b1, 7'd15, 1'b1);
        wait_periods(40);
        end_test();

        // Reverse command stays, so the restart also reverses from zero
        begin_test("brake");
        left_float = 1'b1;
        en = 1'b0;
        repeat (40) @(negedge clk);
        en = 1'b1;
        left_float = 1'b0;
        wait_periods(21);
        end_test();

        begin_test("coast_random");
        for (int i = 0; i < RANDOM_SEGMENTS; i++) begin
            draw_random(r);
            command(duty_t'(r[30:24]), r[23], duty_t'(r[22:16]), r[15]);
            left_float = r[14];
            right_float = r[13];
            // Occasional short brake in the middle of a ramp
            if (r[12:9] == 4'd0) begin
                en = 1'b0;
                repeat (int'(r[8:6]) + 1) @(negedge clk);
                en = 1'b1;
            end
            wait_periods(int'(r[5:0]) % SEGMENT_MAX_PERIODS + 1);
        end
        end_test();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
rtl/motor_pkg.sv
rtl/pwm_period_timer.sv
rtl/duty_slew_limiter.sv
rtl/pwm_dir.sv
rtl/dual_motor_drive.sv
verification/dual_motor_checks.sv
verification/dual_motor_drive_tb.sv

/* Bender.yml */
package:
  name: dual_motor_drive

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/motor_pkg.sv
      - rtl/pwm_period_timer.sv
      - rtl/duty_slew_limiter.sv
      - rtl/pwm_dir.sv
      - rtl/dual_motor_drive.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/dual_motor_checks.sv
      - verification/dual_motor_drive_tb.sv
